//--- lc4_config.svh
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// Core widths and sizes for the reduced LC4 pipeline

// Data path and address width
`define LC4_WORD_W 16

// Architectural register file size
`define LC4_REG_CNT 8

// Bits needed to name one register
`define LC4_SEL_W 3

// First fetch address out of reset
`define LC4_RESET_PC 16'h8200

// Immediate field widths
// ADD immediate form
`define LC4_IMM5_W 5

// CONST value and BR offset
`define LC4_IMM9_W 9

`endif

//--- lc4_pkg.sv
`default_nettype none

`include "lc4_config.svh"

// Types shared across the LC4 core
package lc4_pkg;

  // One data word or one instruction address
  typedef logic [`LC4_WORD_W-1:0] word_t;

  // Register number as encoded in the instruction
  typedef logic [`LC4_SEL_W-1:0] reg_sel_t;

  // Condition codes, N in bit 2, Z in bit 1, P in bit 0
  typedef logic [2:0] nzp_t;

  // Major opcode in bits 15:12
  // Only the supported subset is named, the rest decode as NOP
  typedef enum logic [3:0] {
    OP_BR    = 4'h0,
    OP_ADD   = 4'h1,
    OP_AND   = 4'h5,
    OP_CONST = 4'h9
  } lc4_opcode_e;

  // ALU function picked by the decoder
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_AND,
    ALU_CONST,
    // No result, used for branches and unsupported opcodes
    ALU_NONE
  } alu_op_e;

endpackage

`default_nettype wire

//--- lc4_fetch.sv
`default_nettype none

`include "lc4_config.svh"

module lc4_fetch (
  input  wire            gwe,
  input  wire            i_arst_n,
  // Instruction memory answers in the same cycle
  input  wire lc4_pkg::word_t i_cur_insn,
  // Redirect from execute
  input  wire            i_branch_taken,
  input  wire lc4_pkg::word_t i_branch_target,
  output lc4_pkg::word_t o_cur_pc,
  // Fetch-to-decode latch
  output lc4_pkg::word_t o_d_insn,
  output lc4_pkg::word_t o_d_pc,
  output logic           o_d_valid
);

  lc4_pkg::word_t pc_q;
  lc4_pkg::word_t pc_next;

  // Taken branch wins over sequential fetch
  assign pc_next = i_branch_taken ? i_branch_target : pc_q + 1'b1;

  assign o_cur_pc = pc_q;

  // PC register
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= `LC4_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Decode valid bit
  // The word fetched alongside a taken branch is on the wrong path
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_d_valid <= 1'b0;
    end else begin
      o_d_valid <= ~i_branch_taken;
    end
  end

  // Instruction and its address move into decode every cycle
  always_ff @(posedge gwe) begin
    o_d_insn <= i_cur_insn;
    o_d_pc   <= pc_q;
  end

  // PC must be known at all times once out of reset
  assert property (@(posedge gwe) disable iff (!i_arst_n) !$isunknown(o_cur_pc))
    else $error("Fetch PC is unknown");

endmodule

`default_nettype wire

//--- lc4_decoder.sv
`default_nettype none

`include "lc4_config.svh"

module lc4_decoder (
  input  wire lc4_pkg::word_t i_insn,
  output lc4_pkg::reg_sel_t  o_rs_sel,
  output lc4_pkg::reg_sel_t  o_rt_sel,
  output lc4_pkg::reg_sel_t  o_rd_sel,
  output logic               o_regfile_we,
  output logic               o_nzp_we,
  output logic               o_is_branch,
  output lc4_pkg::alu_op_e   o_alu_op,
  output lc4_pkg::word_t     o_imm,
  output logic               o_use_imm
);

  lc4_pkg::lc4_opcode_e opcode;
  lc4_pkg::word_t       imm5_sx;
  lc4_pkg::word_t       imm9_sx;

  assign opcode = lc4_pkg::lc4_opcode_e'(i_insn[15:12]);

  // Sign-extended immediates
  assign imm5_sx = {{(`LC4_WORD_W-`LC4_IMM5_W){i_insn[`LC4_IMM5_W-1]}},
                    i_insn[`LC4_IMM5_W-1:0]};
  assign imm9_sx = {{(`LC4_WORD_W-`LC4_IMM9_W){i_insn[`LC4_IMM9_W-1]}},
                    i_insn[`LC4_IMM9_W-1:0]};

  always_comb begin
    // Field positions are fixed across the subset
    o_rd_sel     = i_insn[11:9];
    o_rs_sel     = i_insn[8:6];
    o_rt_sel     = i_insn[2:0];
    // Default is a NOP with no side effects
    o_regfile_we = 1'b0;
    o_nzp_we     = 1'b0;
    o_is_branch  = 1'b0;
    o_alu_op     = lc4_pkg::ALU_NONE;
    o_imm        = imm5_sx;
    o_use_imm    = 1'b0;
    case (opcode)
      lc4_pkg::OP_BR: begin
        // Mask 000 never matches, so this also covers NOP
        o_is_branch = 1'b1;
        o_imm       = imm9_sx;
      end
      lc4_pkg::OP_ADD: begin
        if (i_insn[5]) begin
          // ADD Rd, Rs, #imm5
          o_alu_op     = lc4_pkg::ALU_ADD;
          o_use_imm    = 1'b1;
          o_regfile_we = 1'b1;
          o_nzp_we     = 1'b1;
        end else if (i_insn[5:3] == 3'b000) begin
          // ADD Rd, Rs, Rt; MUL, SUB and DIV stay NOPs
          o_alu_op     = lc4_pkg::ALU_ADD;
          o_regfile_we = 1'b1;
          o_nzp_we     = 1'b1;
        end
      end
      lc4_pkg::OP_AND: begin
        // Register form only
        if (i_insn[5:3] == 3'b000) begin
          o_alu_op     = lc4_pkg::ALU_AND;
          o_regfile_we = 1'b1;
          o_nzp_we     = 1'b1;
        end
      end
      lc4_pkg::OP_CONST: begin
        o_alu_op     = lc4_pkg::ALU_CONST;
        o_imm        = imm9_sx;
        o_regfile_we = 1'b1;
        o_nzp_we     = 1'b1;
      end
      default: begin
        // Outside the subset, keep the NOP defaults
      end
    endcase
  end

endmodule

`default_nettype wire

//--- lc4_regfile.sv
`default_nettype none

`include "lc4_config.svh"

module lc4_regfile (
  input  wire                    gwe,
  input  wire                    i_arst_n,
  // Read ports
  input  wire lc4_pkg::reg_sel_t i_rs_sel,
  input  wire lc4_pkg::reg_sel_t i_rt_sel,
  output lc4_pkg::word_t         o_rs_data,
  output lc4_pkg::word_t         o_rt_data,
  // Write port from writeback
  input  wire lc4_pkg::reg_sel_t i_wsel,
  input  wire lc4_pkg::word_t    i_wdata,
  input  wire                    i_we
);

  lc4_pkg::word_t regs [`LC4_REG_CNT];

  // One write per cycle, all registers cleared on reset
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `LC4_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata;
    end
  end

  // Write-through
  // Decode sees the value writeback is storing this cycle
  assign o_rs_data = (i_we && (i_wsel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = (i_we && (i_wsel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- lc4_execute.sv
`default_nettype none

module lc4_execute (
  input  wire                    gwe,
  input  wire                    i_arst_n,
  // Decoded controls
  input  wire lc4_pkg::reg_sel_t i_rs_sel,
  input  wire lc4_pkg::reg_sel_t i_rt_sel,
  input  wire lc4_pkg::reg_sel_t i_rd_sel,
  input  wire                    i_regfile_we,
  input  wire                    i_nzp_we,
  input  wire                    i_is_branch,
  input  wire lc4_pkg::alu_op_e  i_alu_op,
  input  wire lc4_pkg::word_t    i_imm,
  input  wire                    i_use_imm,
  input  wire                    i_d_valid,
  input  wire lc4_pkg::word_t    i_d_pc,
  input  wire lc4_pkg::word_t    i_d_insn,
  // Register file reads from decode
  input  wire lc4_pkg::word_t    i_rs_data,
  input  wire lc4_pkg::word_t    i_rt_data,
  // Redirect to fetch
  output logic                   o_branch_taken,
  output lc4_pkg::word_t         o_branch_target,
  // Writeback stage, also the trace
  output lc4_pkg::reg_sel_t      o_wb_sel,
  output lc4_pkg::word_t         o_wb_data,
  output logic                   o_wb_we,
  output logic                   o_wb_valid,
  output lc4_pkg::word_t         o_wb_pc,
  output lc4_pkg::word_t         o_wb_insn,
  output logic                   o_wb_nzp_we,
  output lc4_pkg::nzp_t          o_wb_nzp
);

  // Execute stage state
  logic              x_valid;
  logic              x_regfile_we;
  logic              x_nzp_we;
  logic              x_is_branch;
  logic              x_use_imm;
  lc4_pkg::alu_op_e  x_alu_op;
  lc4_pkg::reg_sel_t x_rs_sel;
  lc4_pkg::reg_sel_t x_rt_sel;
  lc4_pkg::reg_sel_t x_rd_sel;
  lc4_pkg::word_t    x_pc;
  lc4_pkg::word_t    x_insn;
  lc4_pkg::word_t    x_imm;
  lc4_pkg::word_t    x_rs_data;
  lc4_pkg::word_t    x_rt_data;
  // Architectural condition codes
  lc4_pkg::nzp_t     nzp_q;
  logic              d_keep;
  lc4_pkg::word_t    op_a;
  lc4_pkg::word_t    op_b;
  lc4_pkg::word_t    alu_result;
  lc4_pkg::nzp_t     alu_nzp;
  lc4_pkg::nzp_t     br_nzp;

  // Decode survives only if valid and not behind a taken branch
  assign d_keep = i_d_valid & ~o_branch_taken;

  // Decode-to-execute controls, the single place invalid work is masked
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      x_valid      <= 1'b0;
      x_regfile_we <= 1'b0;
      x_nzp_we     <= 1'b0;
      x_is_branch  <= 1'b0;
      x_alu_op     <= lc4_pkg::ALU_NONE;
    end else begin
      x_valid      <= d_keep;
      x_regfile_we <= i_regfile_we & d_keep;
      x_nzp_we     <= i_nzp_we & d_keep;
      x_is_branch  <= i_is_branch & d_keep;
      x_alu_op     <= d_keep ? i_alu_op : lc4_pkg::ALU_NONE;
    end
  end

  // Decode-to-execute payload
  always_ff @(posedge gwe) begin
    x_pc      <= i_d_pc;
    x_insn    <= i_d_insn;
    x_imm     <= i_imm;
    x_use_imm <= i_use_imm;
    x_rs_sel  <= i_rs_sel;
    x_rt_sel  <= i_rt_sel;
    x_rd_sel  <= i_rd_sel;
    x_rs_data <= i_rs_data;
    x_rt_data <= i_rt_data;
  end

  // Bypass from writeback, older values already came through write-through
  assign op_a = (o_wb_we && (o_wb_sel == x_rs_sel)) ? o_wb_data : x_rs_data;
  assign op_b = (o_wb_we && (o_wb_sel == x_rt_sel)) ? o_wb_data : x_rt_data;

  always_comb begin
    case (x_alu_op)
      lc4_pkg::ALU_ADD:   alu_result = op_a + (x_use_imm ? x_imm : op_b);
      lc4_pkg::ALU_AND:   alu_result = op_a & op_b;
      lc4_pkg::ALU_CONST: alu_result = x_imm;
      default:            alu_result = '0;
    endcase
  end

  // Condition codes of the result
  assign alu_nzp[2] = alu_result[15];
  assign alu_nzp[1] = (alu_result == '0);
  assign alu_nzp[0] = ~alu_result[15] & ~alu_nzp[1];

  // Branch sees the NZP that writeback is about to commit
  assign br_nzp = o_wb_nzp_we ? o_wb_nzp : nzp_q;

  // Mask sits in bits 11:9
  assign o_branch_taken  = x_is_branch & (|(x_insn[11:9] & br_nzp));
  assign o_branch_target = x_pc + 1'b1 + x_imm;

  // Writeback controls and the NZP register
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_valid  <= 1'b0;
      o_wb_we     <= 1'b0;
      o_wb_nzp_we <= 1'b0;
      nzp_q       <= 3'b000;
    end else begin
      o_wb_valid  <= x_valid;
      o_wb_we     <= x_regfile_we;
      o_wb_nzp_we <= x_nzp_we;
      if (o_wb_nzp_we) begin
        nzp_q <= o_wb_nzp;
      end
    end
  end

  // Writeback payload
  always_ff @(posedge gwe) begin
    o_wb_pc   <= x_pc;
    o_wb_insn <= x_insn;
    o_wb_sel  <= x_rd_sel;
    o_wb_data <= alu_result;
    o_wb_nzp  <= alu_nzp;
  end

  // Squash must empty both younger stages behind every taken branch
  // Decode valid comes from fetch, execute valid from the latch above
  assert property (@(posedge gwe) disable iff (!i_arst_n)
                   o_branch_taken |=> (!x_valid && !i_d_valid))
    else $error("Decode or execute valid in the cycle after a taken branch");

endmodule

`default_nettype wire

//--- lc4_core.sv
`default_nettype none

module lc4_core (
  input  wire                    gwe,
  input  wire                    i_arst_n,
  // Instruction memory
  output wire lc4_pkg::word_t    o_cur_pc,
  input  wire lc4_pkg::word_t    i_cur_insn,
  // Writeback trace
  output wire                    o_wb_valid,
  output wire lc4_pkg::word_t    o_wb_pc,
  output wire lc4_pkg::word_t    o_wb_insn,
  output wire                    o_wb_we,
  output wire lc4_pkg::reg_sel_t o_wb_sel,
  output wire lc4_pkg::word_t    o_wb_data,
  output wire                    o_wb_nzp_we,
  output wire lc4_pkg::nzp_t     o_wb_nzp
);

  // Decode stage
  wire lc4_pkg::word_t    d_insn;
  wire lc4_pkg::word_t    d_pc;
  wire                    d_valid;
  wire lc4_pkg::reg_sel_t d_rs_sel;
  wire lc4_pkg::reg_sel_t d_rt_sel;
  wire lc4_pkg::reg_sel_t d_rd_sel;
  wire                    d_regfile_we;
  wire                    d_nzp_we;
  wire                    d_is_branch;
  wire lc4_pkg::alu_op_e  d_alu_op;
  wire lc4_pkg::word_t    d_imm;
  wire                    d_use_imm;
  wire lc4_pkg::word_t    d_rs_data;
  wire lc4_pkg::word_t    d_rt_data;
  // Redirect from execute
  wire                    x_branch_taken;
  wire lc4_pkg::word_t    x_branch_target;

  lc4_fetch u_fetch (
    .gwe             (gwe),
    .i_arst_n        (i_arst_n),
    .i_cur_insn      (i_cur_insn),
    .i_branch_taken  (x_branch_taken),
    .i_branch_target (x_branch_target),
    .o_cur_pc        (o_cur_pc),
    .o_d_insn        (d_insn),
    .o_d_pc          (d_pc),
    .o_d_valid       (d_valid)
  );

  lc4_decoder u_decoder (
    .i_insn       (d_insn),
    .o_rs_sel     (d_rs_sel),
    .o_rt_sel     (d_rt_sel),
    .o_rd_sel     (d_rd_sel),
    .o_regfile_we (d_regfile_we),
    .o_nzp_we     (d_nzp_we),
    .o_is_branch  (d_is_branch),
    .o_alu_op     (d_alu_op),
    .o_imm        (d_imm),
    .o_use_imm    (d_use_imm)
  );

  // Written from writeback, read in decode
  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_arst_n  (i_arst_n),
    .i_rs_sel  (d_rs_sel),
    .i_rt_sel  (d_rt_sel),
    .o_rs_data (d_rs_data),
    .o_rt_data (d_rt_data),
    .i_wsel    (o_wb_sel),
    .i_wdata   (o_wb_data),
    .i_we      (o_wb_we)
  );

  lc4_execute u_execute (
    .gwe             (gwe),
    .i_arst_n        (i_arst_n),
    .i_rs_sel        (d_rs_sel),
    .i_rt_sel        (d_rt_sel),
    .i_rd_sel        (d_rd_sel),
    .i_regfile_we    (d_regfile_we),
    .i_nzp_we        (d_nzp_we),
    .i_is_branch     (d_is_branch),
    .i_alu_op        (d_alu_op),
    .i_imm           (d_imm),
    .i_use_imm       (d_use_imm),
    .i_d_valid       (d_valid),
    .i_d_pc          (d_pc),
    .i_d_insn        (d_insn),
    .i_rs_data       (d_rs_data),
    .i_rt_data       (d_rt_data),
    .o_branch_taken  (x_branch_taken),
    .o_branch_target (x_branch_target),
    .o_wb_sel        (o_wb_sel),
    .o_wb_data       (o_wb_data),
    .o_wb_we         (o_wb_we),
    .o_wb_valid      (o_wb_valid),
    .o_wb_pc         (o_wb_pc),
    .o_wb_insn       (o_wb_insn),
    .o_wb_nzp_we     (o_wb_nzp_we),
    .o_wb_nzp        (o_wb_nzp)
  );

endmodule

`default_nettype wire

//--- tb_lc4_model.svh
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

// Random source, one shared state for every draw
logic [15:0] lfsr_state;

// In-order architectural state
lc4_pkg::word_t m_regs [`LC4_REG_CNT];
lc4_pkg::nzp_t  m_nzp;
lc4_pkg::word_t m_pc;

// Galois LFSR x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Collect n bits, one LFSR step per bit
function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[14:0], lfsr_state[0]};
  end
  return v;
endfunction

// Power-on state of the ISA
task automatic model_reset();
  for (int i = 0; i < `LC4_REG_CNT; i++) begin
    m_regs[i] = '0;
  end
  m_nzp = 3'b000;
  m_pc  = `LC4_RESET_PC;
endtask

// Retire one instruction and report its architectural effects
task automatic model_step(input lc4_pkg::word_t insn, output logic we,
                          output lc4_pkg::reg_sel_t sel, output lc4_pkg::word_t data,
                          output logic nzp_we, output lc4_pkg::nzp_t nzp,
                          output logic taken);
  lc4_pkg::word_t a;
  lc4_pkg::word_t b;
  lc4_pkg::word_t imm5;
  lc4_pkg::word_t imm9;
  we    = 1'b0;
  taken = 1'b0;
  sel   = insn[11:9];
  data  = '0;
  nzp   = 3'b000;
  a     = m_regs[insn[8:6]];
  b     = m_regs[insn[2:0]];
  imm5  = {{11{insn[4]}}, insn[4:0]};
  imm9  = {{7{insn[8]}}, insn[8:0]};
  case (insn[15:12])
    lc4_pkg::OP_ADD: begin
      // Immediate form when bit 5 is set, plain register form for sub-op 000
      if (insn[5]) begin
        we   = 1'b1;
        data = a + imm5;
      end else if (insn[5:3] == 3'b000) begin
        we   = 1'b1;
        data = a + b;
      end
    end
    lc4_pkg::OP_AND: begin
      if (insn[5:3] == 3'b000) begin
        we   = 1'b1;
        data = a & b;
      end
    end
    lc4_pkg::OP_CONST: begin
      we   = 1'b1;
      data = imm9;
    end
    lc4_pkg::OP_BR: begin
      taken = |(insn[11:9] & m_nzp);
    end
    default: begin
    end
  endcase
  nzp_we = we;
  if (we) begin
    // Sign decides N, all zeros decides Z, anything else is P
    nzp = data[15] ? 3'b100 : ((data == '0) ? 3'b010 : 3'b001);
    m_regs[sel] = data;
    m_nzp = nzp;
  end
  m_pc = taken ? (m_pc + 16'd1 + imm9) : (m_pc + 16'd1);
endtask

`endif

//--- tb_lc4_core.sv
`default_nettype none

`include "lc4_config.svh"

module tb_lc4_core;

  localparam int PROGRAMS     = 4;
  localparam int RETIRES      = 300;
  localparam int RESET_CYCLES = 5;
  // Worst case is one retirement every three cycles behind taken branches
  localparam int TIMEOUT_CYCLES = PROGRAMS * (RETIRES * 3 + RESET_CYCLES + 4) + 100;
  localparam logic [15:0] SEED = 16'd39131;

  // Clock starts low without an edge at time zero
  logic              gwe = 1'b0;
  logic              arst_n;
  lc4_pkg::word_t    cur_insn;
  lc4_pkg::word_t    cur_pc;
  logic              wb_valid;
  lc4_pkg::word_t    wb_pc;
  lc4_pkg::word_t    wb_insn;
  logic              wb_we;
  lc4_pkg::reg_sel_t wb_sel;
  lc4_pkg::word_t    wb_data;
  logic              wb_nzp_we;
  lc4_pkg::nzp_t     wb_nzp;

  // Program image, addressed by PC modulo 64
  lc4_pkg::word_t imem [64];
  int             prog_id;
  int             retired;
  int             cycles;
  int             value_errors;
  int             other_errors;
  // Bubble tracking between retirements
  int             gap;
  int             exp_gap;
  logic           exp_taken;

  `include "tb_lc4_model.svh"

  lc4_core i_dut (
    .gwe         (gwe),
    .i_arst_n    (arst_n),
    .o_cur_pc    (cur_pc),
    .i_cur_insn  (cur_insn),
    .o_wb_valid  (wb_valid),
    .o_wb_pc     (wb_pc),
    .o_wb_insn   (wb_insn),
    .o_wb_we     (wb_we),
    .o_wb_sel    (wb_sel),
    .o_wb_data   (wb_data),
    .o_wb_nzp_we (wb_nzp_we),
    .o_wb_nzp    (wb_nzp)
  );

  initial begin
    forever #2 gwe = ~gwe;
  end

  // Instruction memory follows the PC, which only moves on a rising edge
  always @(cur_pc or prog_id) begin
    cur_insn <= imem[cur_pc[5:0]];
  end

  task automatic compare_word(input string name, input lc4_pkg::word_t got,
                              input lc4_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_sel(input string name, input lc4_pkg::reg_sel_t got,
                             input lc4_pkg::reg_sel_t exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_nzp(input string name, input lc4_pkg::nzp_t got,
                             input lc4_pkg::nzp_t exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // Random mix of the supported subset
  task automatic build_program();
    logic [2:0] kind;
    logic [2:0] rd;
    logic [2:0] rs;
    for (int a = 0; a < 64; a++) begin
      kind = 3'(rand_bits(3));
      rd   = 3'(rand_bits(3));
      rs   = 3'(rand_bits(3));
      case (kind)
        3'd0, 3'd1: imem[a] = {lc4_pkg::OP_ADD, rd, rs, 3'b000, 3'(rand_bits(3))};
        3'd2:       imem[a] = {lc4_pkg::OP_ADD, rd, rs, 1'b1, 5'(rand_bits(5))};
        3'd3:       imem[a] = {lc4_pkg::OP_AND, rd, rs, 3'b000, 3'(rand_bits(3))};
        3'd4:       imem[a] = {lc4_pkg::OP_CONST, rd, 9'(rand_bits(9))};
        // BR with a random mask, rd draw serves as the mask
        3'd5, 3'd6: imem[a] = {lc4_pkg::OP_BR, rd, 9'(rand_bits(9))};
        default:    imem[a] = 16'h0000;
      endcase
    end
  endtask

  // Reset the core and the model together and swap in a fresh program
  task automatic restart_with_new_program();
    @(posedge gwe);
    arst_n <= 1'b0;
    retired = 0;
    model_reset();
    build_program();
    prog_id++;
    repeat (RESET_CYCLES) @(posedge gwe);
    arst_n <= 1'b1;
  endtask

  // Compare one retired instruction with the model
  task automatic check_retire();
    lc4_pkg::word_t    insn;
    logic              we;
    lc4_pkg::reg_sel_t sel;
    lc4_pkg::word_t    data;
    logic              nzp_we;
    lc4_pkg::nzp_t     nzp;
    logic              taken;
    insn = imem[m_pc[5:0]];
    compare_word("o_wb_pc", wb_pc, m_pc);
    compare_word("o_wb_insn", wb_insn, insn);
    model_step(insn, we, sel, data, nzp_we, nzp, taken);
    compare_bit("o_wb_we", wb_we, we);
    compare_bit("o_wb_nzp_we", wb_nzp_we, nzp_we);
    if (we) begin
      compare_sel("o_wb_sel", wb_sel, sel);
      compare_word("o_wb_data", wb_data, data);
    end
    if (nzp_we) begin
      compare_nzp("o_wb_nzp", wb_nzp, nzp);
    end
    exp_taken = taken;
  endtask

  // Trace monitor, sampled away from the driving edge
  always @(negedge gwe) begin
    if (!arst_n) begin
      compare_bit("o_wb_valid", wb_valid, 1'b0);
      compare_word("o_cur_pc", cur_pc, `LC4_RESET_PC);
      gap = 0;
      // First fetch needs three cycles to reach writeback
      exp_gap = 3;
    end else if (!wb_valid) begin
      gap++;
    end else begin
      if (gap != exp_gap) begin
        $display("Wrong bubble count at time %0t: %0d invalid cycles before PC %h, wanted %0d",
                 $time, gap, wb_pc, exp_gap);
        other_errors++;
      end
      check_retire();
      gap = 0;
      exp_gap = exp_taken ? 2 : 0;
      retired++;
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge gwe);
      cycles++;
    end
    $display("Run timed out after %0d cycles, program %0d had %0d retirements",
             cycles, prog_id, retired);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    arst_n       = 1'b0;
    cur_insn     = '0;
    lfsr_state   = SEED;
    prog_id      = 0;
    retired      = 0;
    cycles       = 0;
    value_errors = 0;
    other_errors = 0;
    gap          = 0;
    exp_gap      = 3;
    exp_taken    = 1'b0;
    model_reset();
    for (int p = 0; p < PROGRAMS; p++) begin
      restart_with_new_program();
      wait (retired >= RETIRES);
    end
    @(posedge gwe);
    $display("Done: %0d value errors, %0d other errors over %0d programs",
             value_errors, other_errors, PROGRAMS);
    if (value_errors + other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
lc4_pkg.sv
lc4_fetch.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_execute.sv
lc4_core.sv
tb_lc4_core.sv

//--- Bender.yml
package:
  name: lc4_core

export_include_dirs:
  - .

sources:
  - lc4_pkg.sv
  - lc4_fetch.sv
  - lc4_decoder.sv
  - lc4_regfile.sv
  - lc4_execute.sv
  - lc4_core.sv
  - target: test
    files:
      - tb_lc4_core.sv
